//--- uart_pkg.sv
package uart_pkg;

  //////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////
  localparam int DATA_W     = 8;
  localparam int ADDR_W     = 3;
  localparam int DIV_W      = 16;
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = 4;

  // baud ticks per bit, sample point inside a bit
  localparam int OSR     = 16;
  localparam int OSR_W   = 4;
  localparam int OSR_MID = 7;

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////
  localparam logic [ADDR_W-1:0] ADDR_RBR_THR = 3'd0;
  localparam logic [ADDR_W-1:0] ADDR_DLM     = 3'd1;
  localparam logic [ADDR_W-1:0] ADDR_LCR     = 3'd3;
  localparam logic [ADDR_W-1:0] ADDR_LSR     = 3'd5;
  localparam logic [ADDR_W-1:0] ADDR_SCR     = 3'd7;

  // one host bus cycle
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } host_req_t;

  // line control register, bit 7 down to bit 0
  typedef struct packed {
    logic       dlab;
    logic       set_break;
    logic       stick_parity;
    logic       eps;
    logic       pen;
    logic       stb;
    logic [1:0] wls;
  } lcr_t;

  // line status register
  typedef struct packed {
    logic rx_fifo_error;
    logic temt;
    logic thre;
    logic bi;
    logic fe;
    logic pe;
    logic oe;
    logic dr;
  } lsr_t;

  // thre and temt set, everything else clear
  localparam lsr_t LSR_RESET = 8'h60;

  // one received character with its error flags
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              pe;
    logic              fe;
  } rx_frame_t;

endpackage

//--- uart_fifo.sv
module uart_fifo
  import uart_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              push_i,
  input  logic              pop_i,
  input  logic [DATA_W-1:0] din_i,
  output logic [DATA_W-1:0] dout_o,
  output logic              empty_o,
  output logic              full_o,
  output logic              overrun_o
);

  logic [DATA_W-1:0]     mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wptr_q;
  logic [FIFO_PTR_W-1:0] rptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  push_ok;
  logic                  pop_ok;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  // head byte straight out of the array
  assign dout_o = mem[rptr_q];

  always_ff @(posedge clk)
  begin
    if (push_ok)
      mem[wptr_q] <= din_i;
  end

  // pointers wrap naturally at the depth
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wptr_q    <= '0;
      rptr_q    <= '0;
      count_q   <= '0;
      overrun_o <= 1'b0;
    end
    else
    begin
      if (push_ok)
        wptr_q <= wptr_q + 1'b1;
      if (pop_ok)
        rptr_q <= rptr_q + 1'b1;
      if (push_ok && !pop_ok)
        count_q <= count_q + 1'b1;
      else if (pop_ok && !push_ok)
        count_q <= count_q - 1'b1;
      // byte lost, one-cycle flag
      overrun_o <= push_i && full_o;
    end
  end

endmodule

//--- uart_baud_gen.sv
module uart_baud_gen
  import uart_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [DIV_W-1:0] divisor_i,
  input  logic             divisor_load_i,
  output logic             baud_tick_o
);

  logic [DIV_W-1:0] cnt_q;

  // down-counter, period is divisor+1 clocks
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cnt_q       <= '0;
      baud_tick_o <= 1'b0;
    end
    else
    begin
      if (divisor_load_i || (cnt_q == '0))
        cnt_q <= divisor_i;
      else
        cnt_q <= cnt_q - 1'b1;
      // zero divisor means the generator is stopped
      baud_tick_o <= (cnt_q == '0) && (divisor_i != '0);
    end
  end

endmodule

//--- uart_regs.sv
module uart_regs
  import uart_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  host_req_t         req_i,
  input  rx_frame_t         rx_frame_i,
  input  logic              rx_push_i,
  input  logic              rx_overrun_i,
  input  logic              rx_empty_i,
  input  logic              tx_empty_i,
  input  logic              tx_idle_i,
  input  logic [DATA_W-1:0] rx_head_i,
  output lcr_t              lcr_o,
  output logic [DIV_W-1:0]  divisor_o,
  output logic              divisor_load_o,
  output logic              tx_push_o,
  output logic              rx_pop_o,
  output logic [DATA_W-1:0] rdata_o
);

  lcr_t              lcr_q;
  lsr_t              lsr_q;
  logic [DIV_W-1:0]  div_q;
  logic [DATA_W-1:0] scr_q;
  logic [DATA_W-1:0] rd_mux;
  logic              dll_wr;
  logic              dlm_wr;
  logic              lsr_rd;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////
  // addr 0 is the fifo port unless dlab is set
  assign tx_push_o = req_i.wr && (req_i.addr == ADDR_RBR_THR) && !lcr_q.dlab;
  assign rx_pop_o  = req_i.rd && (req_i.addr == ADDR_RBR_THR) && !lcr_q.dlab;
  assign dll_wr    = req_i.wr && (req_i.addr == ADDR_RBR_THR) && lcr_q.dlab;
  assign dlm_wr    = req_i.wr && (req_i.addr == ADDR_DLM) && lcr_q.dlab;
  assign lsr_rd    = req_i.rd && (req_i.addr == ADDR_LSR);

  // lcr, divisor latch and the reload strobe for the baud counter
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      lcr_q          <= '0;
      div_q          <= '0;
      divisor_load_o <= 1'b0;
    end
    else
    begin
      if (req_i.wr && (req_i.addr == ADDR_LCR))
        lcr_q <= req_i.wdata;
      if (dll_wr)
        div_q[DATA_W-1:0] <= req_i.wdata;
      if (dlm_wr)
        div_q[DIV_W-1:DATA_W] <= req_i.wdata;
      // lines up with the new divisor value
      divisor_load_o <= dll_wr || dlm_wr;
    end
  end

  // scratch, plain storage
  always_ff @(posedge clk)
  begin
    if (req_i.wr && (req_i.addr == ADDR_SCR))
      scr_q <= req_i.wdata;
  end

  //////////////////////////////////////////////////
  // line status
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      lsr_q <= LSR_RESET;
    else
    begin
      lsr_q.dr            <= ~rx_empty_i;
      lsr_q.thre          <= tx_empty_i;
      lsr_q.temt          <= tx_empty_i && tx_idle_i;
      lsr_q.bi            <= 1'b0;
      lsr_q.rx_fifo_error <= 1'b0;
      // sticky, a new event beats the clear on read
      lsr_q.oe <= rx_overrun_i || (lsr_q.oe && !lsr_rd);
      lsr_q.pe <= (rx_push_i && rx_frame_i.pe) || (lsr_q.pe && !lsr_rd);
      lsr_q.fe <= (rx_push_i && rx_frame_i.fe) || (lsr_q.fe && !lsr_rd);
    end
  end

  // read mux, unused addresses give zero
  always_comb
  begin
    rd_mux = '0;
    case (req_i.addr)
      ADDR_RBR_THR: rd_mux = lcr_q.dlab ? div_q[DATA_W-1:0] : rx_head_i;
      ADDR_DLM:     rd_mux = lcr_q.dlab ? div_q[DIV_W-1:DATA_W] : '0;
      ADDR_LCR:     rd_mux = lcr_q;
      ADDR_LSR:     rd_mux = lsr_q;
      ADDR_SCR:     rd_mux = scr_q;
      default:      rd_mux = '0;
    endcase
  end

  // held until the next read
  always_ff @(posedge clk)
  begin
    if (req_i.rd)
      rdata_o <= rd_mux;
  end

  assign lcr_o     = lcr_q;
  assign divisor_o = div_q;

endmodule

//--- uart_tx.sv
module uart_tx
  import uart_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              baud_tick_i,
  input  lcr_t              lcr_i,
  input  logic              fifo_empty_i,
  input  logic [DATA_W-1:0] fifo_data_i,
  output logic              fifo_pop_o,
  output logic              idle_o,
  output logic              tx_o
);

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_t;

  tx_state_t         state_q;
  logic [OSR_W-1:0]  tick_cnt_q;
  logic [2:0]        bit_cnt_q;
  logic [DATA_W-1:0] shift_q;
  logic              par_q;
  logic              line_q;
  logic              bit_end;
  logic              stop_done;
  logic              start_frame;
  logic              parity_bit;
  logic [DATA_W-1:0] word_mask;

  // keeps only the wls+5 low bits
  assign word_mask = {DATA_W{1'b1}} >> (2'd3 - lcr_i.wls);
  assign bit_end   = (tick_cnt_q == OSR_W'(OSR - 1));
  assign stop_done = (state_q == TX_STOP) && bit_end && !(lcr_i.stb && (bit_cnt_q == 3'd0));
  // new frame from idle, or right after the last stop bit
  assign start_frame = baud_tick_i && !fifo_empty_i && ((state_q == TX_IDLE) || stop_done);

  // stick parity overrides, else even/odd from eps
  assign parity_bit = lcr_i.stick_parity ? ~lcr_i.eps : (lcr_i.eps ? par_q : ~par_q);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q    <= TX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      line_q     <= 1'b1;
      fifo_pop_o <= 1'b0;
    end
    else
    begin
      fifo_pop_o <= 1'b0;
      if (start_frame)
      begin
        state_q    <= TX_START;
        tick_cnt_q <= '0;
        line_q     <= 1'b0;
        fifo_pop_o <= 1'b1;
      end
      else if (baud_tick_i && (state_q != TX_IDLE))
      begin
        if (!bit_end)
          tick_cnt_q <= tick_cnt_q + 1'b1;
        else
        begin
          tick_cnt_q <= '0;
          case (state_q)
            TX_START:
            begin
              state_q   <= TX_DATA;
              bit_cnt_q <= '0;
              line_q    <= shift_q[0];
            end
            TX_DATA:
            begin
              // last data bit index is wls+4
              if (bit_cnt_q == {1'b1, lcr_i.wls})
              begin
                state_q   <= lcr_i.pen ? TX_PARITY : TX_STOP;
                line_q    <= lcr_i.pen ? parity_bit : 1'b1;
                bit_cnt_q <= '0;
              end
              else
              begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                line_q    <= shift_q[0];
              end
            end
            TX_PARITY:
            begin
              state_q   <= TX_STOP;
              line_q    <= 1'b1;
              bit_cnt_q <= '0;
            end
            TX_STOP:
            begin
              // second stop bit when stb set
              if (lcr_i.stb && (bit_cnt_q == 3'd0))
                bit_cnt_q <= 3'd1;
              else
                state_q <= TX_IDLE;
            end
            default: state_q <= TX_IDLE;
          endcase
        end
      end
    end
  end

  // shift register and parity of the loaded word
  always_ff @(posedge clk)
  begin
    if (start_frame)
    begin
      shift_q <= fifo_data_i;
      par_q   <= ^(fifo_data_i & word_mask);
    end
    else if (baud_tick_i && bit_end && ((state_q == TX_START) || (state_q == TX_DATA)))
      shift_q <= shift_q >> 1;
  end

  // registered pin, break holds it low
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      tx_o <= 1'b1;
    else
      tx_o <= line_q & ~lcr_i.set_break;
  end

  assign idle_o = (state_q == TX_IDLE);

endmodule

//--- uart_rx.sv
module uart_rx
  import uart_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      baud_tick_i,
  input  lcr_t      lcr_i,
  input  logic      rx_i,
  output logic      push_o,
  output rx_frame_t frame_o
);

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_t;

  rx_state_t         state_q;
  logic              rx_meta_q;
  logic              rx_s_q;
  logic [OSR_W-1:0]  tick_cnt_q;
  logic [2:0]        bit_cnt_q;
  logic [DATA_W-1:0] data_q;
  logic [DATA_W-1:0] data_aligned;
  logic              pe_q;
  logic              exp_parity;
  logic              mid;
  logic              bit_end;

  //////////////////////////////////////////////////
  // input synchronizer
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rx_meta_q <= 1'b1;
      rx_s_q    <= 1'b1;
    end
    else
    begin
      rx_meta_q <= rx_i;
      rx_s_q    <= rx_meta_q;
    end
  end

  assign mid     = (tick_cnt_q == OSR_W'(OSR_MID));
  assign bit_end = (tick_cnt_q == OSR_W'(OSR - 1));

  // bits come in at the top, shift down for short words
  assign data_aligned = data_q >> (2'd3 - lcr_i.wls);
  assign exp_parity   = lcr_i.stick_parity ? ~lcr_i.eps :
                        (lcr_i.eps ? ^data_aligned : ~^data_aligned);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q    <= RX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      pe_q       <= 1'b0;
      push_o     <= 1'b0;
    end
    else
    begin
      push_o <= 1'b0;
      if (baud_tick_i)
      begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
        case (state_q)
          RX_IDLE:
          begin
            tick_cnt_q <= '0;
            if (!rx_s_q)
              state_q <= RX_START;
          end
          RX_START:
          begin
            // glitch, line back high at mid start bit
            if (mid && rx_s_q)
              state_q <= RX_IDLE;
            else if (bit_end)
            begin
              state_q   <= RX_DATA;
              bit_cnt_q <= '0;
            end
          end
          RX_DATA:
          begin
            if (bit_end)
            begin
              if (bit_cnt_q == {1'b1, lcr_i.wls})
                state_q <= lcr_i.pen ? RX_PARITY : RX_STOP;
              else
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
          RX_PARITY:
          begin
            if (mid)
              pe_q <= rx_s_q ^ exp_parity;
            if (bit_end)
              state_q <= RX_STOP;
          end
          RX_STOP:
          begin
            // push at mid stop, then hunt for the next start
            if (mid)
            begin
              push_o  <= 1'b1;
              state_q <= RX_IDLE;
            end
          end
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  // data shifter and the frame handed to the fifo
  always_ff @(posedge clk)
  begin
    if (baud_tick_i && mid && (state_q == RX_DATA))
      data_q <= {rx_s_q, data_q[DATA_W-1:1]};
    if (baud_tick_i && mid && (state_q == RX_STOP))
    begin
      frame_o.data <= data_aligned;
      frame_o.pe   <= lcr_i.pen && pe_q;
      frame_o.fe   <= ~rx_s_q;
    end
  end

endmodule

//--- uart_top.sv
module uart_top
  import uart_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  host_req_t         req_i,
  input  logic              rx_i,
  output logic              tx_o,
  output logic [DATA_W-1:0] rdata_o
);

  lcr_t              lcr;
  rx_frame_t         rx_frame;
  logic [DIV_W-1:0]  divisor;
  logic              divisor_load;
  logic              baud_tick;
  logic              tx_push;
  logic              tx_pop;
  logic              tx_empty;
  logic              tx_idle;
  logic [DATA_W-1:0] tx_head;
  logic              rx_push;
  logic              rx_pop;
  logic              rx_empty;
  logic              rx_overrun;
  logic [DATA_W-1:0] rx_head;

  //////////////////////////////////////////////////
  // host registers and baud tick
  //////////////////////////////////////////////////
  uart_regs u_regs (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req_i),
    .rx_frame_i     (rx_frame),
    .rx_push_i      (rx_push),
    .rx_overrun_i   (rx_overrun),
    .rx_empty_i     (rx_empty),
    .tx_empty_i     (tx_empty),
    .tx_idle_i      (tx_idle),
    .rx_head_i      (rx_head),
    .lcr_o          (lcr),
    .divisor_o      (divisor),
    .divisor_load_o (divisor_load),
    .tx_push_o      (tx_push),
    .rx_pop_o       (rx_pop),
    .rdata_o        (rdata_o)
  );

  uart_baud_gen u_baud (
    .clk            (clk),
    .rst            (rst),
    .divisor_i      (divisor),
    .divisor_load_i (divisor_load),
    .baud_tick_o    (baud_tick)
  );

  //////////////////////////////////////////////////
  // transmit path
  //////////////////////////////////////////////////
  // tx overrun unused, a full fifo just drops the write
  uart_fifo tx_fifo (
    .clk       (clk),
    .rst       (rst),
    .push_i    (tx_push),
    .pop_i     (tx_pop),
    .din_i     (req_i.wdata),
    .dout_o    (tx_head),
    .empty_o   (tx_empty),
    .full_o    (),
    .overrun_o ()
  );

  uart_tx u_tx (
    .clk          (clk),
    .rst          (rst),
    .baud_tick_i  (baud_tick),
    .lcr_i        (lcr),
    .fifo_empty_i (tx_empty),
    .fifo_data_i  (tx_head),
    .fifo_pop_o   (tx_pop),
    .idle_o       (tx_idle),
    .tx_o         (tx_o)
  );

  //////////////////////////////////////////////////
  // receive path
  //////////////////////////////////////////////////
  uart_rx u_rx (
    .clk         (clk),
    .rst         (rst),
    .baud_tick_i (baud_tick),
    .lcr_i       (lcr),
    .rx_i        (rx_i),
    .push_o      (rx_push),
    .frame_o     (rx_frame)
  );

  uart_fifo rx_fifo (
    .clk       (clk),
    .rst       (rst),
    .push_i    (rx_push),
    .pop_i     (rx_pop),
    .din_i     (rx_frame.data),
    .dout_o    (rx_head),
    .empty_o   (rx_empty),
    .full_o    (),
    .overrun_o (rx_overrun)
  );

endmodule

//--- tb_uart.sv
module tb_uart
  import uart_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DIVISOR  = 1;
  localparam int BIT_CLKS = OSR * (DIVISOR + 1);
  localparam int WAIT_MAX = 20 * BIT_CLKS;

  logic              clk;
  logic              rst;
  host_req_t         req;
  logic              rx_line;
  logic              tx_line;
  logic [DATA_W-1:0] rdata;
  logic [15:0]       lfsr_q;
  int                mismatches;
  int                timeouts;

  uart_top dut (
    .clk     (clk),
    .rst     (rst),
    .req_i   (req),
    .rx_i    (rx_line),
    .tx_o    (tx_line),
    .rdata_o (rdata)
  );

  // 40 ns period
  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // timing, bus and stimulus helpers
  //////////////////////////////////////////////////
  // every step lands 1 ns after the rising edge
  task automatic next_cycle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // one strobe cycle, then one idle cycle
  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    req.wr    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    next_cycle(1);
    req = '0;
    next_cycle(1);
  endtask

  // rdata is valid right after the strobe cycle ends
  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    req.rd   = 1'b1;
    req.addr = addr;
    next_cycle(1);
    req  = '0;
    data = rdata;
    next_cycle(1);
  endtask

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic rand_byte(output logic [DATA_W-1:0] b);
    int i;
    for (i = 0; i < DATA_W; i++)
    begin
      b[i]   = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // wls+5 low bits
  function automatic logic [DATA_W-1:0] word_mask(input lcr_t l);
    return 8'((9'd1 << (int'(l.wls) + 5)) - 1);
  endfunction

  // xor for even, inverse for odd, stick gives ~eps
  function automatic logic calc_parity(input logic [DATA_W-1:0] d, input lcr_t l);
    logic x;
    x = ^(d & word_mask(l));
    if (l.stick_parity)
      return ~l.eps;
    return l.eps ? x : ~x;
  endfunction

  // thre and temt always set in these tests
  function automatic lsr_t lsr_expect(input logic dr, input logic oe, input logic pe,
                                      input logic fe);
    lsr_t v;
    v      = '0;
    v.temt = 1'b1;
    v.thre = 1'b1;
    v.dr   = dr;
    v.oe   = oe;
    v.pe   = pe;
    v.fe   = fe;
    return v;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_byte(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s, got 0x%02h expected 0x%02h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_lsr(input lsr_t got, input lsr_t exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s, lsr 0x%02h expected 0x%02h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_line(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // first read shows the error, second read has it cleared
  task automatic check_sticky(input lsr_t exp, input string what);
    logic [DATA_W-1:0] r;
    lsr_t              cleared;
    cleared    = exp;
    cleared.oe = 1'b0;
    cleared.pe = 1'b0;
    cleared.fe = 1'b0;
    bus_read(ADDR_LSR, r);
    check_lsr(r, exp, {what, ", first lsr read"});
    bus_read(ADDR_LSR, r);
    check_lsr(r, cleared, {what, ", second lsr read"});
  endtask

  //////////////////////////////////////////////////
  // serial encoder and decoder
  //////////////////////////////////////////////////
  task automatic send_frame(input lcr_t l, input logic [DATA_W-1:0] d, input logic par,
                            input logic stop);
    int i;
    rx_line = 1'b0;
    next_cycle(BIT_CLKS);
    // lsb first
    for (i = 0; i < int'(l.wls) + 5; i++)
    begin
      rx_line = d[i];
      next_cycle(BIT_CLKS);
    end
    if (l.pen)
    begin
      rx_line = par;
      next_cycle(BIT_CLKS);
    end
    rx_line = stop;
    if (stop)
      next_cycle(BIT_CLKS);
    else
    begin
      // low only past the stop sample, so the retry start check finds idle
      next_cycle(BIT_CLKS / 2 + 4);
      rx_line = 1'b1;
      next_cycle(BIT_CLKS + BIT_CLKS / 2 - 4);
    end
  endtask

  // returns at the middle of the first stop bit
  task automatic decode_frame(input lcr_t l, output logic [DATA_W-1:0] data, output logic par,
                              output int waited);
    int n;
    data   = '0;
    par    = 1'b0;
    waited = 0;
    while ((tx_line !== 1'b0) && (waited < WAIT_MAX))
    begin
      next_cycle(1);
      waited++;
    end
    if (tx_line !== 1'b0)
    begin
      $display("timeout at %0t: no start bit on tx_o within %0d clocks", $time, WAIT_MAX);
      timeouts++;
      return;
    end
    next_cycle(BIT_CLKS / 2);
    check_line(tx_line, 1'b0, "tx start bit");
    for (n = 0; n < int'(l.wls) + 5; n++)
    begin
      next_cycle(BIT_CLKS);
      data[n] = tx_line;
    end
    if (l.pen)
    begin
      next_cycle(BIT_CLKS);
      par = tx_line;
    end
    next_cycle(BIT_CLKS);
    check_line(tx_line, 1'b1, "tx stop bit");
  endtask

  // poll lsr until the transmitter has drained
  task automatic wait_tx_done();
    logic [DATA_W-1:0] r;
    lsr_t              v;
    int                n;
    v = '0;
    for (n = 0; (n < WAIT_MAX) && !v.temt; n++)
    begin
      bus_read(ADDR_LSR, r);
      v = r;
    end
    if (!v.temt)
    begin
      $display("timeout at %0t: transmitter never went empty", $time);
      timeouts++;
    end
    check_lsr(v, lsr_expect(1'b0, 1'b0, 1'b0, 1'b0), "lsr after transmit");
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic test_registers();
    logic [DATA_W-1:0] r;
    int                i;
    bus_read(ADDR_LSR, r);
    check_lsr(r, lsr_expect(1'b0, 1'b0, 1'b0, 1'b0), "lsr after reset");
    bus_write(ADDR_SCR, 8'hA5);
    bus_read(ADDR_SCR, r);
    check_byte(r, 8'hA5, "scratch readback");
    bus_write(ADDR_LCR, 8'h1B);
    bus_read(ADDR_LCR, r);
    check_byte(r, 8'h1B, "lcr readback");
    // divisor latch behind dlab
    bus_write(ADDR_LCR, 8'h83);
    bus_write(ADDR_RBR_THR, 8'h34);
    bus_write(ADDR_DLM, 8'h12);
    bus_read(ADDR_RBR_THR, r);
    check_byte(r, 8'h34, "dll readback");
    bus_read(ADDR_DLM, r);
    check_byte(r, 8'h12, "dlm readback");
    bus_write(ADDR_RBR_THR, 8'(DIVISOR));
    bus_write(ADDR_DLM, 8'(DIVISOR >> 8));
    bus_write(ADDR_LCR, 8'h03);
    // addresses 1 2 4 6 with dlab clear
    for (i = 0; i < 4; i++)
    begin
      bus_read(ADDR_W'((i == 0) ? 1 : 2 * i), r);
      check_byte(r, 8'h00, "unused address");
    end
  endtask

  // back to back frames where the gap checks the stop length
  task automatic test_tx_frames(input lcr_t l, input int nbytes);
    logic [DATA_W-1:0] sent [$];
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] got;
    logic              par;
    int                waited;
    int                i;
    bus_write(ADDR_LCR, l);
    for (i = 0; i < nbytes; i++)
    begin
      rand_byte(b);
      sent.push_back(b & word_mask(l));
      bus_write(ADDR_RBR_THR, b);
    end
    for (i = 0; i < nbytes; i++)
    begin
      decode_frame(l, got, par, waited);
      check_byte(got, sent[i], "tx data");
      if (l.pen)
        check_line(par, calc_parity(sent[i], l), "tx parity bit");
      // first frame is already on the line while the bytes are written
      if (i > 1)
        check_byte(8'(waited), 8'(BIT_CLKS / 2 + (l.stb ? BIT_CLKS : 0)),
                   "clocks from stop middle to next start");
    end
    wait_tx_done();
  endtask

  task automatic test_tx_options();
    lcr_t modes [5];
    int   i;
    modes[0] = 8'h1A;
    modes[1] = 8'h08;
    // stick parity with both eps values
    modes[2] = 8'h2B;
    modes[3] = 8'h3B;
    // two stop bits
    modes[4] = 8'h07;
    for (i = 0; i < 5; i++)
      test_tx_frames(modes[i], 3);
    bus_write(ADDR_LCR, 8'h43);
    for (i = 0; i < 4; i++)
    begin
      next_cycle(BIT_CLKS / 4);
      check_line(tx_line, 1'b0, "tx held low by break");
    end
    bus_write(ADDR_LCR, 8'h03);
    next_cycle(2);
    check_line(tx_line, 1'b1, "tx idle after break");
  endtask

  task automatic test_rx();
    lcr_t              modes [4];
    logic [DATA_W-1:0] expect_q [$];
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] r;
    int                i;
    // 8n1, 5n1, 7 bits even, 6 bits even
    modes[0] = 8'h03;
    modes[1] = 8'h00;
    modes[2] = 8'h1A;
    modes[3] = 8'h19;
    for (i = 0; i < 4; i++)
    begin
      bus_write(ADDR_LCR, modes[i]);
      rand_byte(b);
      send_frame(modes[i], b, calc_parity(b, modes[i]), 1'b1);
      expect_q.push_back(b & word_mask(modes[i]));
      bus_read(ADDR_LSR, r);
      check_lsr(r, lsr_expect(1'b1, 1'b0, 1'b0, 1'b0), "lsr with rx data waiting");
    end
    for (i = 0; i < 4; i++)
    begin
      bus_read(ADDR_RBR_THR, r);
      check_byte(r, expect_q[i], "rx data");
    end
    bus_read(ADDR_LSR, r);
    check_lsr(r, lsr_expect(1'b0, 1'b0, 1'b0, 1'b0), "lsr after rx drain");
  endtask

  task automatic test_rx_errors();
    logic [DATA_W-1:0] expect_q [$];
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] r;
    lcr_t              l;
    int                i;
    // wrong parity on an 8 bit even frame
    l = 8'h1B;
    bus_write(ADDR_LCR, l);
    rand_byte(b);
    send_frame(l, b, ~calc_parity(b, l), 1'b1);
    check_sticky(lsr_expect(1'b1, 1'b0, 1'b1, 1'b0), "parity error");
    bus_read(ADDR_RBR_THR, r);
    check_byte(r, b, "data of the parity error frame");
    // low stop bit
    l = 8'h03;
    bus_write(ADDR_LCR, l);
    rand_byte(b);
    send_frame(l, b, 1'b0, 1'b0);
    check_sticky(lsr_expect(1'b1, 1'b0, 1'b0, 1'b1), "framing error");
    bus_read(ADDR_RBR_THR, r);
    check_byte(r, b, "data of the framing error frame");
    // one frame more than the fifo holds
    for (i = 0; i < FIFO_DEPTH + 1; i++)
    begin
      rand_byte(b);
      if (i < FIFO_DEPTH)
        expect_q.push_back(b);
      send_frame(l, b, 1'b0, 1'b1);
    end
    check_sticky(lsr_expect(1'b1, 1'b1, 1'b0, 1'b0), "overrun");
    for (i = 0; i < FIFO_DEPTH; i++)
    begin
      bus_read(ADDR_RBR_THR, r);
      check_byte(r, expect_q[i], "rx data before the overrun");
    end
    bus_read(ADDR_LSR, r);
    check_lsr(r, lsr_expect(1'b0, 1'b0, 1'b0, 1'b0), "lsr after overrun drain");
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    req        = '0;
    rx_line    = 1'b1;
    lfsr_q     = 16'd23;
    mismatches = 0;
    timeouts   = 0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle(1);
    test_registers();
    test_tx_frames(8'h03, 4);
    test_tx_options();
    test_rx();
    test_rx_errors();
    $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if ((mismatches == 0) && (timeouts == 0))
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- sources.f
uart_pkg.sv
uart_fifo.sv
uart_baud_gen.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_uart -f sources.f -o tb_uart_sim
./obj_dir/tb_uart_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  echo "run passed"
  exit 0
fi
echo "run failed"
exit 1
